//--- common/clock_display_pkg.sv
package clock_display_pkg;

    // screen and bus widths
    localparam int H_CELL_W    = 7;
    localparam int V_PIX_W     = 10;
    localparam int ROW_W       = 6;
    localparam int GLYPH_ROW_W = 4;
    localparam int NIBBLE_W    = 4;
    localparam int POS_W       = 4;
    localparam int CURSOR_W    = 9;

    // pair indices, same as the posicion codes on the bus
    localparam logic [POS_W-1:0] PAIR_DAY   = 4'd0;
    localparam logic [POS_W-1:0] PAIR_MONTH = 4'd1;
    localparam logic [POS_W-1:0] PAIR_YEAR  = 4'd2;
    localparam logic [POS_W-1:0] PAIR_SEC   = 4'd3;
    localparam logic [POS_W-1:0] PAIR_MIN   = 4'd4;
    localparam logic [POS_W-1:0] PAIR_HOUR  = 4'd5;
    localparam logic [POS_W-1:0] PAIR_TSEC  = 4'd6;
    localparam logic [POS_W-1:0] PAIR_TMIN  = 4'd7;
    localparam logic [POS_W-1:0] PAIR_THOUR = 4'd8;
    localparam int               NUM_PAIRS  = 9;

    // a digit is two cells wide, a pair is tens then units
    localparam int DIGIT_CELLS = 2;
    localparam int PAIR_CELLS  = 4;

    // first cell of each pair
    localparam logic [H_CELL_W-1:0] COL_HOUR     = 7'd10;
    localparam logic [H_CELL_W-1:0] COL_MIN      = 7'd16;
    localparam logic [H_CELL_W-1:0] COL_SEC      = 7'd22;
    localparam logic [H_CELL_W-1:0] COL_THOUR    = 7'd66;
    localparam logic [H_CELL_W-1:0] COL_TMIN     = 7'd72;
    localparam logic [H_CELL_W-1:0] COL_TSEC     = 7'd78;
    localparam logic [H_CELL_W-1:0] COL_DAY      = 7'd34;
    localparam logic [H_CELL_W-1:0] COL_MONTH    = 7'd42;
    localparam logic [H_CELL_W-1:0] COL_YEAR     = 7'd52;
    localparam logic [H_CELL_W-1:0] YEAR_LIT_COL = 7'd48;

    // largest valid tens digit per field
    localparam logic [NIBBLE_W-1:0] TENS_MAX_HOUR  = 4'd2;
    localparam logic [NIBBLE_W-1:0] TENS_MAX_MS    = 4'd5;
    localparam logic [NIBBLE_W-1:0] TENS_MAX_DAY   = 4'd3;
    localparam logic [NIBBLE_W-1:0] TENS_MAX_MONTH = 4'd1;
    localparam logic [NIBBLE_W-1:0] TENS_MAX_YEAR  = 4'd9;
    localparam logic [NIBBLE_W-1:0] UNITS_MAX      = 4'd9;

    // character ROM codes, zero lives at 10
    localparam logic [NIBBLE_W-1:0] ZERO_GLYPH    = 4'd10;
    localparam logic [NIBBLE_W-1:0] BLANK_GLYPH   = 4'd0;
    localparam logic [NIBBLE_W-1:0] CENTURY_GLYPH = 4'd2;

    // edit field counter values
    localparam logic [1:0] FIELD_SEC   = 2'd0;
    localparam logic [1:0] FIELD_MIN   = 2'd1;
    localparam logic [1:0] FIELD_HOUR  = 2'd2;
    localparam logic [1:0] FIELD_DAY   = 2'd0;
    localparam logic [1:0] FIELD_MONTH = 2'd1;
    localparam logic [1:0] FIELD_YEAR  = 2'd2;

    // hour tens carries the pm flag in its top bit
    typedef union packed {
        logic [NIBBLE_W-1:0] bcd;
        struct packed {
            logic                pm;
            logic [NIBBLE_W-2:0] digit;
        } hr;
    } hour_tens_u;

    typedef struct packed {
        hour_tens_u          tens;
        logic [NIBBLE_W-1:0] units;
    } digit_pair_t;

    typedef struct packed {
        digit_pair_t [NUM_PAIRS-1:0] pair;
    } display_digits_t;

    typedef struct packed {
        logic                   on_digit;
        logic [POS_W-1:0]       pair_id;
        logic                   units;
        logic                   on_literal;
        logic [NIBBLE_W-1:0]    literal_code;
        logic [GLYPH_ROW_W-1:0] glyph_row;
    } cell_loc_t;

    typedef struct packed {
        logic [NIBBLE_W-1:0]    code;
        logic [GLYPH_ROW_W-1:0] row;
    } glyph_addr_t;

endpackage

//--- source/digit_store.sv
`timescale 1ns/100ps

module digit_store (
    input  logic                                reloj,
    input  logic                                resetM,
    input  logic                                read,
    input  logic [clock_display_pkg::POS_W-1:0] posicion,
    input  clock_display_pkg::digit_pair_t      dato,
    output clock_display_pkg::display_digits_t  digits,
    output logic                                am_pm
);
    import clock_display_pkg::*;

    logic wr_en;

    // posicion codes 9 to 15 name no pair
    assign wr_en = read && (posicion < NUM_PAIRS);

    // one pair per strobe, visible the next cycle
    always_ff @(posedge reloj) begin
        if (resetM) begin
            digits <= '0;
        end else if (wr_en) begin
            digits.pair[posicion] <= dato;
        end
    end

    // pm flag rides on top of the clock hour tens
    assign am_pm = digits.pair[PAIR_HOUR].tens.hr.pm;

endmodule

//--- display/screen_locator.sv
`timescale 1ns/100ps

module screen_locator #(
    parameter logic [clock_display_pkg::ROW_W-1:0] TIME_ROW = 6'd12,
    parameter logic [clock_display_pkg::ROW_W-1:0] DATE_ROW = 6'd17
) (
    input  logic                                   reloj,
    input  logic                                   resetM,
    input  logic [clock_display_pkg::H_CELL_W-1:0] h_cell,
    input  logic [clock_display_pkg::V_PIX_W-1:0]  v_pix,
    output clock_display_pkg::cell_loc_t           loc
);
    import clock_display_pkg::*;

    logic [ROW_W-1:0]       text_row;
    logic [GLYPH_ROW_W-1:0] glyph_row;
    logic                   hit;
    logic [POS_W-1:0]       hit_pair;
    logic [H_CELL_W-1:0]    hit_col;
    logic                   lit_hit;
    logic [NIBBLE_W-1:0]    lit_code;
    cell_loc_t              loc_d;

    function automatic logic in_pair(
        input logic [H_CELL_W-1:0] col,
        input logic [H_CELL_W-1:0] start
    );
        in_pair = (col >= start) && (col < start + PAIR_CELLS);
    endfunction

    assign text_row  = v_pix[V_PIX_W-1:GLYPH_ROW_W];
    assign glyph_row = v_pix[GLYPH_ROW_W-1:0];

    // which pair, if any, covers this cell
    always_comb begin
        hit      = 1'b1;
        hit_pair = '0;
        hit_col  = '0;
        if (text_row == TIME_ROW && in_pair(h_cell, COL_HOUR)) begin
            hit_pair = PAIR_HOUR;
            hit_col  = COL_HOUR;
        end else if (text_row == TIME_ROW && in_pair(h_cell, COL_MIN)) begin
            hit_pair = PAIR_MIN;
            hit_col  = COL_MIN;
        end else if (text_row == TIME_ROW && in_pair(h_cell, COL_SEC)) begin
            hit_pair = PAIR_SEC;
            hit_col  = COL_SEC;
        end else if (text_row == TIME_ROW && in_pair(h_cell, COL_THOUR)) begin
            hit_pair = PAIR_THOUR;
            hit_col  = COL_THOUR;
        end else if (text_row == TIME_ROW && in_pair(h_cell, COL_TMIN)) begin
            hit_pair = PAIR_TMIN;
            hit_col  = COL_TMIN;
        end else if (text_row == TIME_ROW && in_pair(h_cell, COL_TSEC)) begin
            hit_pair = PAIR_TSEC;
            hit_col  = COL_TSEC;
        end else if (text_row == DATE_ROW && in_pair(h_cell, COL_DAY)) begin
            hit_pair = PAIR_DAY;
            hit_col  = COL_DAY;
        end else if (text_row == DATE_ROW && in_pair(h_cell, COL_MONTH)) begin
            hit_pair = PAIR_MONTH;
            hit_col  = COL_MONTH;
        end else if (text_row == DATE_ROW && in_pair(h_cell, COL_YEAR)) begin
            hit_pair = PAIR_YEAR;
            hit_col  = COL_YEAR;
        end else begin
            hit = 1'b0;
        end
    end

    // fixed "20" ahead of the two year digits
    assign lit_hit  = (text_row == DATE_ROW) && in_pair(h_cell, YEAR_LIT_COL);
    assign lit_code = (h_cell < YEAR_LIT_COL + DIGIT_CELLS) ? CENTURY_GLYPH : ZERO_GLYPH;

    always_comb begin
        loc_d              = '0;
        loc_d.glyph_row    = glyph_row;
        loc_d.on_digit     = hit;
        loc_d.pair_id      = hit_pair;
        loc_d.units        = hit && (h_cell >= hit_col + DIGIT_CELLS);
        loc_d.on_literal   = lit_hit;
        loc_d.literal_code = lit_hit ? lit_code : BLANK_GLYPH;
    end

    always_ff @(posedge reloj) begin
        if (resetM) begin
            loc <= '0;
        end else begin
            loc <= loc_d;
        end
    end

endmodule

//--- display/glyph_address.sv
`timescale 1ns/100ps

module glyph_address (
    input  logic                               reloj,
    input  logic                               resetM,
    input  logic                               read,
    input  clock_display_pkg::display_digits_t digits,
    input  clock_display_pkg::cell_loc_t       loc,
    output clock_display_pkg::glyph_addr_t     dir_mem
);
    import clock_display_pkg::*;

    digit_pair_t         sel;
    logic [NIBBLE_W-1:0] digit;
    logic [NIBBLE_W-1:0] tens_max;
    logic                digit_ok;
    logic [NIBBLE_W-1:0] code;
    glyph_addr_t         addr_d;

    // tens limit for the located field
    always_comb begin
        case (loc.pair_id)
            PAIR_DAY:              tens_max = TENS_MAX_DAY;
            PAIR_MONTH:            tens_max = TENS_MAX_MONTH;
            PAIR_YEAR:             tens_max = TENS_MAX_YEAR;
            PAIR_HOUR, PAIR_THOUR: tens_max = TENS_MAX_HOUR;
            default:               tens_max = TENS_MAX_MS;
        endcase
    end

    always_comb begin
        sel = digits.pair[loc.pair_id];
        if (loc.units) begin
            digit    = sel.units;
            digit_ok = (sel.units <= UNITS_MAX);
        end else if (loc.pair_id == PAIR_HOUR) begin
            // drop the pm flag, so 8 to 10 read as 0 to 2
            digit    = {1'b0, sel.tens.hr.digit};
            digit_ok = (digit <= tens_max);
        end else begin
            digit    = sel.tens.bcd;
            digit_ok = (digit <= tens_max);
        end
    end

    // zero sits at its own ROM slot
    always_comb begin
        if (!digit_ok) begin
            code = BLANK_GLYPH;
        end else if (digit == '0) begin
            code = ZERO_GLYPH;
        end else begin
            code = digit;
        end
    end

    always_comb begin
        addr_d = '0;
        if (loc.on_literal) begin
            addr_d.code = loc.literal_code;
            addr_d.row  = loc.glyph_row;
        end else if (loc.on_digit) begin
            addr_d.code = code;
            addr_d.row  = loc.glyph_row;
        end
    end

    // address freezes while the bus is writing
    always_ff @(posedge reloj) begin
        if (resetM) begin
            dir_mem <= '0;
        end else if (!read) begin
            dir_mem <= addr_d;
        end
    end

endmodule

//--- display/cursor_marker.sv
`timescale 1ns/100ps

module cursor_marker (
    input  logic                                   reloj,
    input  logic                                   resetM,
    input  clock_display_pkg::cell_loc_t           loc,
    input  logic                                   edit_time,
    input  logic                                   edit_date,
    input  logic                                   edit_timer,
    input  logic [1:0]                             field_time,
    input  logic [1:0]                             field_date,
    input  logic [1:0]                             field_timer,
    output logic [clock_display_pkg::CURSOR_W-1:0] cam_co
);
    import clock_display_pkg::*;

    logic [CURSOR_W-1:0] mark_d;

    // msb first: time h/m/s, timer h/m/s, day, month, year
    always_comb begin
        mark_d = '0;
        if (loc.on_digit) begin
            case (loc.pair_id)
                PAIR_HOUR:  mark_d[8] = edit_time && (field_time == FIELD_HOUR);
                PAIR_MIN:   mark_d[7] = edit_time && (field_time == FIELD_MIN);
                PAIR_SEC:   mark_d[6] = edit_time && (field_time == FIELD_SEC);
                PAIR_THOUR: mark_d[5] = edit_timer && (field_timer == FIELD_HOUR);
                PAIR_TMIN:  mark_d[4] = edit_timer && (field_timer == FIELD_MIN);
                PAIR_TSEC:  mark_d[3] = edit_timer && (field_timer == FIELD_SEC);
                PAIR_DAY:   mark_d[2] = edit_date && (field_date == FIELD_DAY);
                PAIR_MONTH: mark_d[1] = edit_date && (field_date == FIELD_MONTH);
                PAIR_YEAR:  mark_d[0] = edit_date && (field_date == FIELD_YEAR);
                default:    mark_d    = '0;
            endcase
        end
    end

    always_ff @(posedge reloj) begin
        if (resetM) begin
            cam_co <= '0;
        end else begin
            cam_co <= mark_d;
        end
    end

endmodule

//--- source/clock_display_top.sv
`timescale 1ns/100ps

module clock_display_top #(
    parameter logic [clock_display_pkg::ROW_W-1:0] TIME_ROW = 6'd12,
    parameter logic [clock_display_pkg::ROW_W-1:0] DATE_ROW = 6'd17
) (
    input  logic                                  reloj,
    input  logic                                  resetM,
    input  logic                                  read,
    input  logic [clock_display_pkg::POS_W-1:0]   posicion,
    input  clock_display_pkg::digit_pair_t        dato,
    input  logic [clock_display_pkg::H_CELL_W-1:0] h_cell,
    input  logic [clock_display_pkg::V_PIX_W-1:0] v_pix,
    input  logic                                  edit_time,
    input  logic                                  edit_date,
    input  logic                                  edit_timer,
    input  logic [1:0]                            field_time,
    input  logic [1:0]                            field_date,
    input  logic [1:0]                            field_timer,
    output clock_display_pkg::glyph_addr_t        dir_mem,
    output logic [clock_display_pkg::CURSOR_W-1:0] cam_co,
    output logic                                  am_pm
);
    import clock_display_pkg::*;

    display_digits_t digits;
    cell_loc_t       loc;

    digit_store u_digit_store (
        .reloj    (reloj),
        .resetM   (resetM),
        .read     (read),
        .posicion (posicion),
        .dato     (dato),
        .digits   (digits),
        .am_pm    (am_pm)
    );

    screen_locator #(
        .TIME_ROW (TIME_ROW),
        .DATE_ROW (DATE_ROW)
    ) u_screen_locator (
        .reloj  (reloj),
        .resetM (resetM),
        .h_cell (h_cell),
        .v_pix  (v_pix),
        .loc    (loc)
    );

    glyph_address u_glyph_address (
        .reloj   (reloj),
        .resetM  (resetM),
        .read    (read),
        .digits  (digits),
        .loc     (loc),
        .dir_mem (dir_mem)
    );

    cursor_marker u_cursor_marker (
        .reloj       (reloj),
        .resetM      (resetM),
        .loc         (loc),
        .edit_time   (edit_time),
        .edit_date   (edit_date),
        .edit_timer  (edit_timer),
        .field_time  (field_time),
        .field_date  (field_date),
        .field_timer (field_timer),
        .cam_co      (cam_co)
    );

endmodule

//--- dv/display_model.svh
`ifndef DISPLAY_MODEL_SVH
`define DISPLAY_MODEL_SVH

// reference copy of the pairs and the two stages behind the counters
digit_pair_t         pairs_ref [NUM_PAIRS];
cell_loc_t           cell_ref;
glyph_addr_t         addr_ref;
logic [CURSOR_W-1:0] cursor_ref;

// tens cell of each pair on screen
function automatic int pair_col(input int p);
    case (p)
        0: pair_col = 34;
        1: pair_col = 42;
        2: pair_col = 52;
        3: pair_col = 22;
        4: pair_col = 16;
        5: pair_col = 10;
        6: pair_col = 78;
        7: pair_col = 72;
        default: pair_col = 66;
    endcase
endfunction

function automatic cell_loc_t locate_cell(input logic [6:0] col, input logic [9:0] vp);
    cell_loc_t c;
    int x;
    int row;
    int start;
    c = '0;
    x = int'(col);
    row = int'(vp[9:4]);
    c.glyph_row = vp[3:0];
    for (int p = 0; p < 9; p++) begin
        start = pair_col(p);
        if (row == ((p < 3) ? DATE_TEXT_ROW : TIME_TEXT_ROW) && x >= start && x < start + 4) begin
            c.on_digit = 1'b1;
            c.pair_id  = 4'(p);
            c.units    = (x >= start + 2);
        end
    end
    // century digits in front of the year
    if (row == DATE_TEXT_ROW && x >= 48 && x < 52) begin
        c.on_literal   = 1'b1;
        c.literal_code = (x < 50) ? 4'd2 : 4'd10;
    end
    return c;
endfunction

function automatic glyph_addr_t addr_for_cell(input cell_loc_t c);
    glyph_addr_t a;
    digit_pair_t dp;
    int d;
    int lim;
    a = '0;
    if (c.on_literal) begin
        a.code = c.literal_code;
        a.row  = c.glyph_row;
    end else if (c.on_digit) begin
        dp = pairs_ref[c.pair_id];
        case (int'(c.pair_id))
            0: lim = 3;
            1: lim = 1;
            2: lim = 9;
            5, 8: lim = 2;
            default: lim = 5;
        endcase
        if (c.units) begin
            d = int'(dp.units);
            lim = 9;
        end else if (c.pair_id == 4'd5) begin
            // clock hour tens, pm flag left out
            d = int'(dp.tens.bcd[2:0]);
        end else begin
            d = int'(dp.tens.bcd);
        end
        if (d > lim) begin
            a.code = 4'd0;
        end else if (d == 0) begin
            a.code = 4'd10;
        end else begin
            a.code = 4'(d);
        end
        a.row = c.glyph_row;
    end
    return a;
endfunction

function automatic logic [CURSOR_W-1:0] cursor_for_cell(input cell_loc_t c);
    logic [CURSOR_W-1:0] m;
    int p;
    m = '0;
    p = int'(c.pair_id);
    if (c.on_digit) begin
        if (p >= 3 && p <= 5) begin
            m[p + 3] = edit_time && (int'(field_time) == p - 3);
        end else if (p >= 6) begin
            m[p - 3] = edit_timer && (int'(field_timer) == p - 6);
        end else begin
            m[2 - p] = edit_date && (int'(field_date) == p);
        end
    end
    return m;
endfunction

task automatic clear_model();
    foreach (pairs_ref[i]) begin
        pairs_ref[i] = '0;
    end
    cell_ref   = '0;
    addr_ref   = '0;
    cursor_ref = '0;
endtask

// one rising edge with the inputs that were held across it
task automatic step_model();
    glyph_addr_t a_next;
    a_next = read ? addr_ref : addr_for_cell(cell_ref);
    cursor_ref = cursor_for_cell(cell_ref);
    addr_ref   = a_next;
    cell_ref   = locate_cell(h_cell, v_pix);
    if (read && posicion < 4'd9) begin
        pairs_ref[posicion] = dato;
    end
endtask

`endif

//--- dv/clock_display_tb.sv
`timescale 1ns/100ps

module clock_display_tb;
    import clock_display_pkg::*;

    localparam int RESET_CYCLES   = 5;
    localparam int NUM_CYCLES     = 3000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 3;
    localparam int TIME_TEXT_ROW  = 12;
    localparam int DATE_TEXT_ROW  = 17;

    logic                reloj = 1'b0;
    logic                resetM;
    logic                read;
    logic [POS_W-1:0]    posicion;
    digit_pair_t         dato;
    logic [H_CELL_W-1:0] h_cell;
    logic [V_PIX_W-1:0]  v_pix;
    logic                edit_time;
    logic                edit_date;
    logic                edit_timer;
    logic [1:0]          field_time;
    logic [1:0]          field_date;
    logic [1:0]          field_timer;
    glyph_addr_t         dir_mem;
    logic [CURSOR_W-1:0] cam_co;
    logic                am_pm;

    logic [31:0] lcg_state = 32'hfd3645cb;
    int          cycle_count = 0;

    `include "display_model.svh"

    clock_display_top dut (
        .reloj       (reloj),
        .resetM      (resetM),
        .read        (read),
        .posicion    (posicion),
        .dato        (dato),
        .h_cell      (h_cell),
        .v_pix       (v_pix),
        .edit_time   (edit_time),
        .edit_date   (edit_date),
        .edit_timer  (edit_timer),
        .field_time  (field_time),
        .field_date  (field_date),
        .field_timer (field_timer),
        .dir_mem     (dir_mem),
        .cam_co      (cam_co),
        .am_pm       (am_pm)
    );

    always #4 reloj = ~reloj;

    always @(posedge reloj) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_addr(input glyph_addr_t expected, input glyph_addr_t actual);
        if (actual !== expected) begin
            $display("Error at %0t: dir_mem expected %h actual %h", $time, expected, actual);
            $display("Verification failed");
            $fatal(1, "dir_mem mismatch");
        end
    endtask

    task automatic check_cursor(input logic [CURSOR_W-1:0] expected,
                                input logic [CURSOR_W-1:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t: cam_co expected %b actual %b", $time, expected, actual);
            $display("Verification failed");
            $fatal(1, "cam_co mismatch");
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at %0t: am_pm expected %b actual %b", $time, expected, actual);
            $display("Verification failed");
            $fatal(1, "am_pm mismatch");
        end
    endtask

    task automatic drive_random();
        logic [31:0] r_bus;
        logic [31:0] r_dat;
        logic [31:0] r_scr;
        logic [31:0] r_edit;
        logic [5:0]  row;
        r_bus  = next_rand();
        r_dat  = next_rand();
        r_scr  = next_rand();
        r_edit = next_rand();
        // roughly one write strobe every three cycles
        read     = ((r_bus[31:16] % 16'd3) == 16'd0);
        posicion = r_dat[23:20];
        dato     = r_dat[31:24];
        // mostly the two text rows that carry fields
        case (r_scr[31:29])
            3'd0, 3'd1, 3'd2: row = 6'(TIME_TEXT_ROW);
            3'd3, 3'd4, 3'd5: row = 6'(DATE_TEXT_ROW);
            default: row = r_scr[28:23];
        endcase
        v_pix       = {row, r_scr[22:19]};
        h_cell      = 7'(r_scr[18:8] % 11'd91);
        edit_time   = r_edit[31];
        edit_date   = r_edit[30];
        edit_timer  = r_edit[29];
        field_time  = r_edit[28:27];
        field_date  = r_edit[26:25];
        field_timer = r_edit[24:23];
    endtask

    initial begin
        resetM      = 1'b1;
        read        = 1'b0;
        posicion    = '0;
        dato        = '0;
        h_cell      = '0;
        v_pix       = '0;
        edit_time   = 1'b0;
        edit_date   = 1'b0;
        edit_timer  = 1'b0;
        field_time  = '0;
        field_date  = '0;
        field_timer = '0;
        clear_model();

        // outputs settle by the falling edge, compare there then drive
        for (int i = 0; i < RESET_CYCLES + NUM_CYCLES; i++) begin
            @(negedge reloj);
            if (resetM) begin
                clear_model();
            end else begin
                step_model();
            end
            check_addr(addr_ref, dir_mem);
            check_cursor(cursor_ref, cam_co);
            check_flag(pairs_ref[PAIR_HOUR].tens.bcd[3], am_pm);
            if (i + 1 >= RESET_CYCLES) begin
                resetM = 1'b0;
                drive_random();
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

//--- clock_display_top.f
+incdir+dv
common/clock_display_pkg.sv
source/digit_store.sv
display/screen_locator.sv
display/glyph_address.sv
display/cursor_marker.sv
source/clock_display_top.sv
dv/clock_display_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the clock display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module clock_display_tb \
    -f clock_display_top.f \
    -o clock_display_sim

./obj_dir/clock_display_sim
